//--- video_testdata.txt
# W addr data | R addr expected | P x y red green blue
# All fields hex, one operation per line
W 20 03
W 25 07
W 43 E5
W 47 1A
W 52 B6
W 00 21
W 8B 81
W 8C 10
W 12 21
W 09 20
W 85 00
W 30 5A
R 20 03
R 25 07
R 43 E5
R 00 21
R 8B 81
R 30 00
P 00 03 5 5 4
P 07 03 5 5 4
P 00 04 7 1 2
P 03 04 5 5 4
P 09 0D 7 1 2
P 13 14 5 5 4
P 14 14 0 6 4
P 01 03 7 1 2

//--- sources.f
video_pkg.sv
cpu_bus_pkg.sv
video_timing.sv
video_cpu_port.sv
video_txt.sv
video_bck.sv
video_colmix.sv
video_top.sv
video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- video_tb.sv
// Testbench for the video board. Runs Wishbone cycles, readback checks
// and pixel checks listed in video_testdata.txt, and watches blanking.

module video_tb;
    import video_pkg::*;
    import cpu_bus_pkg::*;

    localparam logic [31:0] SEED = 32'hbfc8;
    localparam int ACK_TMO = 20;        // Cycles
    localparam int PIX_TMO = 12000;     // About two frames of cycles

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    bus_addr_t   wb_adr;
    bus_data_t   wb_dat_w;
    bus_data_t   wb_dat_r;
    logic        wb_ack;
    hpos_t       out_h;
    vpos_t       out_v;
    logic        hb;
    logic        vb;
    chan_t       red;
    chan_t       green;
    chan_t       blue;
    int          errors;
    int          checks;
    int          blank_seen;
    logic [31:0] rnd;

    video_top UUT (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   ),
        .out_h    ( out_h    ),
        .out_v    ( out_v    ),
        .hb       ( hb       ),
        .vb       ( vb       ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Pixel step on every second cycle, random phase
    initial begin
        rnd     = xorshift(SEED);
        pxl_cen = rnd[0];
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;
        end
    end

    // One Wishbone classic cycle; request held through the ack edge
    task automatic bus_cycle(input logic we, input bus_addr_t adr, input bus_data_t dat,
                             output bus_data_t rdat);
        int n;
        n = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        while (!wb_ack && n < ACK_TMO) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            $display("Timeout: no ack for the bus cycle at address 0x%02h", adr);
            errors++;
        end
        rdat = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input bus_addr_t adr, input bus_data_t expect_d);
        bus_data_t rdat;
        bus_cycle(1'b0, adr, '0, rdat);
        checks++;
        if (rdat !== expect_d) begin
            $display("** Error at %0t: read 0x%02h gave 0x%02h, expected 0x%02h",
                     $time, adr, rdat, expect_d);
            errors++;
        end
    endtask

    // Counts pixel steps so that the 3-step pipeline holds fresh RAM data
    task automatic wait_steps(input int steps);
        int cnt;
        int k;
        cnt = 0;
        k   = 0;
        while (cnt < steps && k < 4 * steps + 4) begin
            @(posedge clk);
            k++;
            if (pxl_cen) cnt++;
        end
        if (cnt < steps) begin
            $display("Timeout: pixel enable stopped toggling");
            errors++;
        end
    endtask

    task automatic watch_blanking();
        if (hb || vb) begin
            blank_seen++;
            if (red !== '0 || green !== '0 || blue !== '0) begin
                $display("** Error at %0t: colour %0d/%0d/%0d during blanking",
                         $time, red, green, blue);
                errors++;
            end
        end
    endtask

    task automatic pixel_check(input hpos_t x, input vpos_t y, input chan_t r,
                               input chan_t g, input chan_t b);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        wait_steps(4);
        while (!found && n < PIX_TMO) begin
            @(negedge clk);
            n++;
            watch_blanking();
            if (out_h == x && out_v == y && !hb && !vb) found = 1'b1;
        end
        if (!found) begin
            $display("Timeout: pixel (%0d,%0d) never reached the output", x, y);
            errors++;
        end else begin
            checks++;
            if (red !== r || green !== g || blue !== b) begin
                $display("** Error at %0t: pixel (%0d,%0d) is %0d/%0d/%0d, expected %0d/%0d/%0d",
                         $time, x, y, red, green, blue, r, g, b);
                errors++;
            end
        end
    endtask

    // A short line would leave stale fields behind
    task automatic fields_check(input int got, input int want);
        if (got != want) begin
            $display("Malformed line in the stimulus file: %0d of %0d fields read", got, want);
            errors++;
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
    endtask

    initial begin
        int          fd;
        int          code;
        logic        done;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        bus_data_t   rdat;
        errors     = 0;
        checks     = 0;
        blank_seen = 0;
        done       = 1'b0;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        repeat (4) @(negedge clk);
        checks++;
        if (hb !== 1'b0 || vb !== 1'b0 || wb_ack !== 1'b0 || out_h !== '0 || out_v !== '0 ||
            red !== '0 || green !== '0 || blue !== '0) begin
            $display("** Error at %0t: outputs not cleared by reset", $time);
            errors++;
        end
        rst_n = 1'b1;

        fd = $fopen("video_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file video_testdata.txt");
            errors++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (op)
                    "#": skip_line(fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        fields_check(code, 2);
                        bus_cycle(1'b1, a[7:0], b[7:0], rdat);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        fields_check(code, 2);
                        read_check(a[7:0], b[7:0]);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                        fields_check(code, 5);
                        pixel_check(a[7:0], b[7:0], c[2:0], d[2:0], e[2:0]);
                    end
                    default: begin
                        $display("Unknown operation code '%c' in the stimulus file", op);
                        errors++;
                        skip_line(fd);
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);

        if (blank_seen == 0) begin
            $display("Blanking was never seen while waiting for pixels");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- video_top.sv
// Video board top level. Wires raster timing, text and background
// layers, colour mixer and the Wishbone port together.

module video_top #(
    parameter int h_active = 64,
    parameter int h_total  = 80,
    parameter int v_active = 32,
    parameter int v_total  = 36
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  cpu_bus_pkg::bus_addr_t wb_adr,
    input  cpu_bus_pkg::bus_data_t wb_dat_w,
    output cpu_bus_pkg::bus_data_t wb_dat_r,
    output logic                   wb_ack,
    output video_pkg::hpos_t       out_h,
    output video_pkg::vpos_t       out_v,
    output logic                   hb,
    output logic                   vb,
    output video_pkg::chan_t       red,
    output video_pkg::chan_t       green,
    output video_pkg::chan_t       blue
);
    import video_pkg::*;
    import cpu_bus_pkg::*;

    hpos_t     h;
    vpos_t     v;
    logic      tim_hb;
    logic      tim_vb;
    col4_t     txt_col;
    logic      txt_on;
    col4_t     bck_col;
    loc_addr_t loc_addr;
    bus_data_t loc_data;
    logic      txt_we, bck_we, pal_we, gly_we;
    bus_data_t txt_rd, bck_rd, pal_rd, gly_rd;

    video_timing #(
        .h_active ( h_active ),
        .h_total  ( h_total  ),
        .v_active ( v_active ),
        .v_total  ( v_total  )
    ) u_timing (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .h       ( h       ),
        .v       ( v       ),
        .hb      ( tim_hb  ),
        .vb      ( tim_vb  )
    );

    video_cpu_port u_cpu (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   ),
        .loc_addr ( loc_addr ),
        .loc_data ( loc_data ),
        .txt_we   ( txt_we   ),
        .bck_we   ( bck_we   ),
        .pal_we   ( pal_we   ),
        .gly_we   ( gly_we   ),
        .txt_rd   ( txt_rd   ),
        .bck_rd   ( bck_rd   ),
        .pal_rd   ( pal_rd   ),
        .gly_rd   ( gly_rd   )
    );

    video_txt u_txt (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .h        ( h        ),
        .v        ( v        ),
        .loc_addr ( loc_addr ),
        .loc_data ( loc_data ),
        .txt_we   ( txt_we   ),
        .gly_we   ( gly_we   ),
        .txt_rd   ( txt_rd   ),
        .gly_rd   ( gly_rd   ),
        .txt_col  ( txt_col  ),
        .txt_on   ( txt_on   )
    );

    video_bck u_bck (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .h        ( h        ),
        .v        ( v        ),
        .loc_addr ( loc_addr ),
        .loc_data ( loc_data ),
        .bck_we   ( bck_we   ),
        .bck_rd   ( bck_rd   ),
        .bck_col  ( bck_col  )
    );

    video_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .h        ( h        ),
        .v        ( v        ),
        .hb       ( tim_hb   ),
        .vb       ( tim_vb   ),
        .txt_col  ( txt_col  ),
        .txt_on   ( txt_on   ),
        .bck_col  ( bck_col  ),
        .loc_addr ( loc_addr ),
        .loc_data ( loc_data ),
        .pal_we   ( pal_we   ),
        .pal_rd   ( pal_rd   ),
        .out_h    ( out_h    ),
        .out_v    ( out_v    ),
        .out_hb   ( hb       ),
        .out_vb   ( vb       ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

//--- video_colmix.sv
// Colour mixer. Text wins over background, the result goes through the
// palette RAM and is blanked. Coordinates and blanking are delayed so
// that every output describes the same pixel.

module video_colmix (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  video_pkg::hpos_t       h,
    input  video_pkg::vpos_t       v,
    input  logic                   hb,
    input  logic                   vb,
    input  video_pkg::col4_t       txt_col,
    input  logic                   txt_on,
    input  video_pkg::col4_t       bck_col,
    input  cpu_bus_pkg::loc_addr_t loc_addr,
    input  cpu_bus_pkg::bus_data_t loc_data,
    input  logic                   pal_we,
    output cpu_bus_pkg::bus_data_t pal_rd,
    output video_pkg::hpos_t       out_h,
    output video_pkg::vpos_t       out_v,
    output logic                   out_hb,
    output logic                   out_vb,
    output video_pkg::chan_t       red,
    output video_pkg::chan_t       green,
    output video_pkg::chan_t       blue
);
    import video_pkg::*;

    localparam int DLY = 3;     // Two layer steps plus the palette read

    rgb_t              pal_ram [0:31];
    pal_idx_t          pal_idx;
    rgb_t              pal_word;
    logic              blank;
    hpos_t [DLY-1:0]   h_d;
    vpos_t [DLY-1:0]   v_d;
    logic  [DLY-1:0]   hb_d;
    logic  [DLY-1:0]   vb_d;

    always_ff @(posedge clk) begin
        if (pal_we) pal_ram[loc_addr[4:0]] <= loc_data;
    end

    assign pal_rd = pal_ram[loc_addr[4:0]];

    assign pal_idx  = txt_on ? (PAL_TXT_BASE | pal_idx_t'(txt_col)) : pal_idx_t'(bck_col);
    assign pal_word = pal_ram[pal_idx];
    assign blank    = hb_d[DLY-2] | vb_d[DLY-2];   // Lines up with the layer data

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_d   <= '0;
            v_d   <= '0;
            hb_d  <= '0;
            vb_d  <= '0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            h_d   <= {h_d[DLY-2:0], h};
            v_d   <= {v_d[DLY-2:0], v};
            hb_d  <= {hb_d[DLY-2:0], hb};
            vb_d  <= {vb_d[DLY-2:0], vb};
            red   <= blank ? '0 : pal_word[7:5];
            green <= blank ? '0 : pal_word[4:2];
            blue  <= blank ? '0 : {pal_word[1:0], 1'b0};   // LSB always zero
        end
    end

    assign out_h  = h_d[DLY-1];
    assign out_v  = v_d[DLY-1];
    assign out_hb = hb_d[DLY-1];
    assign out_vb = vb_d[DLY-1];

endmodule

//--- video_bck.sv
// Background layer of 16x16 solid blocks, 4 by 2 on screen.
// The extra register keeps it in step with the text layer.

module video_bck (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  video_pkg::hpos_t       h,
    input  video_pkg::vpos_t       v,
    input  cpu_bus_pkg::loc_addr_t loc_addr,
    input  cpu_bus_pkg::bus_data_t loc_data,
    input  logic                   bck_we,
    output cpu_bus_pkg::bus_data_t bck_rd,
    output video_pkg::col4_t       bck_col
);
    import video_pkg::*;
    import cpu_bus_pkg::*;

    bus_data_t  bck_ram [0:7];      // Colour in the low nibble
    logic [2:0] blk_addr;
    col4_t      blk_q;

    assign blk_addr = {v[4], h[5:4]};

    always_ff @(posedge clk) begin
        if (bck_we) bck_ram[loc_addr[2:0]] <= loc_data;
    end

    assign bck_rd = bck_ram[loc_addr[2:0]];

    always_ff @(posedge clk) begin
        if (pxl_cen) blk_q <= bck_ram[blk_addr][3:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)       bck_col <= '0;
        else if (pxl_cen) bck_col <= blk_q;     // Match text latency
    end

endmodule

//--- video_txt.sv
// Text layer, 8x8 characters on an 8 by 4 tile map.
// Stage 1 reads the tile entry, stage 2 the glyph row. Results are
// ready two pixel steps after the coordinates that selected them.

module video_txt (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  video_pkg::hpos_t       h,
    input  video_pkg::vpos_t       v,
    input  cpu_bus_pkg::loc_addr_t loc_addr,
    input  cpu_bus_pkg::bus_data_t loc_data,
    input  logic                   txt_we,
    input  logic                   gly_we,
    output cpu_bus_pkg::bus_data_t txt_rd,
    output cpu_bus_pkg::bus_data_t gly_rd,
    output video_pkg::col4_t       txt_col,
    output logic                   txt_on
);
    import video_pkg::*;
    import cpu_bus_pkg::*;

    bus_data_t  tile_ram [0:31];    // High nibble colour, low nibble code
    bus_data_t  gly_ram  [0:127];   // 16 characters of 8 rows
    logic [4:0] tile_addr;

    bus_data_t  tile_q;
    logic [2:0] col1;
    logic [2:0] row1;

    bus_data_t  gly_q;
    logic [2:0] col2;

    assign tile_addr = {v[4:3], h[5:3]};   // Column plus 8 times row

    always_ff @(posedge clk) begin
        if (txt_we) tile_ram[loc_addr[4:0]] <= loc_data;
        if (gly_we) gly_ram[loc_addr]       <= loc_data;
    end

    assign txt_rd = tile_ram[loc_addr[4:0]];
    assign gly_rd = gly_ram[loc_addr];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            tile_q <= tile_ram[tile_addr];
            col1   <= h[2:0];
            row1   <= v[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gly_q   <= '0;
            txt_col <= '0;
            col2    <= '0;
        end else if (pxl_cen) begin
            gly_q   <= gly_ram[{tile_q[3:0], row1}];
            txt_col <= tile_q[7:4];
            col2    <= col1;
        end
    end

    // Bit 7 is the leftmost pixel of the row
    assign txt_on = gly_q[3'd7 - col2];

endmodule

//--- video_cpu_port.sv
// Wishbone classic slave for the video RAMs, 8-bit data.
// Decodes the region, writes on the first cycle of a request and
// answers with a one-cycle ack. Read data is held while ack is high.

module video_cpu_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  cpu_bus_pkg::bus_addr_t wb_adr,
    input  cpu_bus_pkg::bus_data_t wb_dat_w,
    output cpu_bus_pkg::bus_data_t wb_dat_r,
    output logic                   wb_ack,
    output cpu_bus_pkg::loc_addr_t loc_addr,
    output cpu_bus_pkg::bus_data_t loc_data,
    output logic                   txt_we,
    output logic                   bck_we,
    output logic                   pal_we,
    output logic                   gly_we,
    input  cpu_bus_pkg::bus_data_t txt_rd,
    input  cpu_bus_pkg::bus_data_t bck_rd,
    input  cpu_bus_pkg::bus_data_t pal_rd,
    input  cpu_bus_pkg::bus_data_t gly_rd
);
    import cpu_bus_pkg::*;

    region_t   region;
    logic      go;
    bus_data_t rd_sel;

    assign region = addr_region(wb_adr);
    assign go     = wb_cyc & wb_stb & ~wb_ack;  // Ack low forces a gap cycle

    assign loc_addr = wb_adr[6:0];
    assign loc_data = wb_dat_w;

    assign txt_we = go & wb_we & (region == REG_TXT);
    assign bck_we = go & wb_we & (region == REG_BCK);
    assign pal_we = go & wb_we & (region == REG_PAL);
    assign gly_we = go & wb_we & (region == REG_GLY);

    always_comb begin
        case (region)
            REG_TXT: rd_sel = txt_rd;
            REG_BCK: rd_sel = bck_rd;
            REG_PAL: rd_sel = pal_rd;
            REG_GLY: rd_sel = gly_rd;
            default: rd_sel = '0;           // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) wb_ack <= 1'b0;
        else        wb_ack <= go;
    end

    always_ff @(posedge clk) begin
        if (go) wb_dat_r <= wb_we ? '0 : rd_sel;
    end

    // The master must keep its request up until it sees the ack
    a_ack_stb: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    );
    a_one_we: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({txt_we, bck_we, pal_we, gly_we})
    );

endmodule

//--- video_timing.sv
// Raster counters for the video board.
// h and v advance once per pixel step, blanking flags decode the active area.

module video_timing #(
    parameter int h_active = 64,
    parameter int h_total  = 80,
    parameter int v_active = 32,
    parameter int v_total  = 36
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    output video_pkg::hpos_t h,
    output video_pkg::vpos_t v,
    output logic             hb,
    output logic             vb
);
    import video_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = (h == hpos_t'(h_total - 1));
    assign v_last = (v == vpos_t'(v_total - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                h <= '0;
                v <= v_last ? '0 : v + 1'b1;    // New line
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // Blanking outside the active area
    assign hb = (h >= hpos_t'(h_active));
    assign vb = (v >= vpos_t'(v_active));

    a_h_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h < hpos_t'(h_total)) && (v < vpos_t'(v_total))
    );

endmodule

//--- cpu_bus_pkg.sv
// CPU bus widths and the address map of the video RAMs.
// The decode function is shared by the bus port and its checks.

package cpu_bus_pkg;

    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;
    typedef logic [6:0] loc_addr_t;     // Offset inside a region

    typedef enum logic [2:0] {
        REG_NONE,
        REG_TXT,    // 0x00-0x1F tile RAM
        REG_BCK,    // 0x20-0x27 background RAM
        REG_PAL,    // 0x40-0x5F palette
        REG_GLY     // 0x80-0xFF glyph RAM
    } region_t;

    function automatic region_t addr_region(input bus_addr_t adr);
        region_t r;
        casez (adr)
            8'b1???_????: r = REG_GLY;
            8'b000?_????: r = REG_TXT;
            8'b0010_0???: r = REG_BCK;
            8'b010?_????: r = REG_PAL;
            default:      r = REG_NONE;
        endcase
        return r;
    endfunction

endpackage

//--- video_pkg.sv
// Raster and colour types shared by the video blocks.
// Import inside a module body, or use scoped names in port lists.

package video_pkg;

    typedef logic [7:0] hpos_t;     // Pixel within a line
    typedef logic [7:0] vpos_t;     // Line within a frame

    // Entries 0..15 hold the background colours, 16..31 the text colours
    typedef logic [4:0] pal_idx_t;

    typedef logic [3:0] col4_t;     // Colour code from one layer

    // Palette word, packed as RRRGGGBB
    typedef logic [7:0] rgb_t;

    typedef logic [2:0] chan_t;     // One output channel

    // First palette entry used by the text layer
    localparam pal_idx_t PAL_TXT_BASE = 5'd16;

endpackage
